// File: i2c_slave.f
src/i2c_slave_pkg.sv
src/i2c_line_sync.sv
src/i2c_bit_counter.sv
src/i2c_byte_path.sv
src/i2c_slave_fsm.sv
src/i2c_slave_top.sv
tb/tb_i2c_slave.sv

// File: src/i2c_bit_counter.sv
`timescale 1ns/1ps

module i2c_bit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,    // Wins over step
    input  logic step,
    output logic last_bit  // Eighth bit of the byte
);

    logic [i2c_slave_pkg::BIT_CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;  // Wraps 7 -> 0
        end
    end

    // All ones means bit 7
    assign last_bit = (count == {i2c_slave_pkg::BIT_CNT_W{1'b1}});

endmodule

// File: src/i2c_byte_path.sv
`timescale 1ns/1ps

module i2c_byte_path (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  i2c_slave_pkg::i2c_shift_ctl_t        ctl,
    input  logic                                 sda_in,
    input  logic [i2c_slave_pkg::ADDR_W-1:0]     slave_addr,
    input  logic [i2c_slave_pkg::BYTE_W-1:0]     tx_data,
    output logic [i2c_slave_pkg::BYTE_W-1:0]     rx_data,
    output logic                                 addr_hit,
    output i2c_slave_pkg::i2c_dir_t              rw,
    output logic                                 tx_bit
);

    localparam int BW = i2c_slave_pkg::BYTE_W;

    logic [BW-1:0] addr_reg;  // Address + R/W, MSB first
    logic [BW-1:0] rx_reg;
    logic [BW-1:0] tx_reg;

    // ========================================
    // Receive side
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_reg <= '0;
            rx_reg   <= '0;
        end else begin
            if (ctl.addr_shift) begin
                addr_reg <= {addr_reg[BW-2:0], sda_in};
            end
            if (ctl.rx_shift) begin
                rx_reg <= {rx_reg[BW-2:0], sda_in};
            end
        end
    end

    // ========================================
    // Transmit side
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_reg <= '0;
        end else if (ctl.tx_load) begin
            tx_reg <= tx_data;
        end else if (ctl.tx_shift) begin
            tx_reg <= {tx_reg[BW-2:0], 1'b0};  // Next bit into MSB
        end
    end

    assign tx_bit  = tx_reg[BW-1];
    assign rx_data = rx_reg;

    // Sampled by the FSM on the eighth SCL rise, before the R/W bit lands,
    // so the seven address bits still sit at the bottom of the register
    assign addr_hit = (addr_reg[BW-2:0] == slave_addr);

    // Valid once all eight bits are in
    assign rw = i2c_slave_pkg::i2c_dir_t'(addr_reg[0]);

endmodule

// File: src/i2c_line_sync.sv
`timescale 1ns/1ps

module i2c_line_sync #(
    parameter int SYNC_STAGES = 3  // 2 or more
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      scl,
    input  logic                      sda_pin,
    output i2c_slave_pkg::i2c_bus_ev_t ev
);

    // Newest sample in bit 0, oldest in the top bit
    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES-1:0] sda_sync;
    logic                   sda_prev;  // Synced SDA, one cycle older
    logic                   scl_s;
    logic                   sda_s;

    // ========================================
    // Synchronizers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_sync <= '1;  // Bus idles high
            sda_sync <= '1;
            sda_prev <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[SYNC_STAGES-2:0], scl};
            sda_sync <= {sda_sync[SYNC_STAGES-2:0], sda_pin};
            sda_prev <= sda_s;
        end
    end

    assign scl_s = scl_sync[SYNC_STAGES-1];
    assign sda_s = sda_sync[SYNC_STAGES-1];

    // ========================================
    // Events
    // ========================================
    // Edges from the two oldest SCL stages
    assign ev.scl_rise = ~scl_s & scl_sync[SYNC_STAGES-2];
    assign ev.scl_fall = scl_s & ~scl_sync[SYNC_STAGES-2];
    assign ev.scl_high = scl_s;
    assign ev.sda_in   = sda_s;

    // START / STOP only valid with SCL held high
    assign ev.start = sda_prev & ~sda_s & scl_s;
    assign ev.stop  = ~sda_prev & sda_s & scl_s;

endmodule

// File: src/i2c_slave_fsm.sv
`timescale 1ns/1ps

module i2c_slave_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  i2c_slave_pkg::i2c_bus_ev_t    ev,
    input  logic                          last_bit,
    input  logic                          addr_hit,
    input  i2c_slave_pkg::i2c_dir_t       rw,
    input  logic                          tx_bit,
    output logic                          cnt_clear,
    output logic                          cnt_step,
    output i2c_slave_pkg::i2c_shift_ctl_t ctl,
    output logic                          sda_out,
    output logic                          sda_oe,
    output i2c_slave_pkg::i2c_status_t    status
);

    i2c_slave_pkg::i2c_state_t  state, state_d;
    i2c_slave_pkg::i2c_status_t status_d;
    logic                       sda_out_d;
    logic                       sda_oe_d;

    // ========================================
    // State and output registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= i2c_slave_pkg::IDLE;
            sda_out <= 1'b1;
            sda_oe  <= 1'b0;  // Released
            status  <= '0;
        end else begin
            state   <= state_d;
            sda_out <= sda_out_d;
            sda_oe  <= sda_oe_d;
            status  <= status_d;
        end
    end

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_d             = state;
        sda_out_d           = sda_out;
        sda_oe_d            = sda_oe;
        status_d            = status;
        status_d.data_valid = 1'b0;  // Pulse only
        cnt_clear           = 1'b0;
        cnt_step            = 1'b0;
        ctl                 = '0;

        if (ev.stop && (state != i2c_slave_pkg::IDLE)) begin
            // STOP ends any transfer
            state_d             = i2c_slave_pkg::IDLE;
            sda_oe_d            = 1'b0;
            cnt_clear           = 1'b1;
            status_d.addr_match = 1'b0;
            status_d.ack_sent   = 1'b0;
        end else begin
            case (state)
                i2c_slave_pkg::IDLE: begin
                    sda_oe_d            = 1'b0;
                    cnt_clear           = 1'b1;
                    status_d.addr_match = 1'b0;
                    status_d.ack_sent   = 1'b0;
                    if (ev.start) state_d = i2c_slave_pkg::START;
                end

                i2c_slave_pkg::START: begin
                    sda_oe_d  = 1'b0;
                    cnt_clear = 1'b1;
                    // First SCL low after START, address MSB follows
                    if (ev.scl_fall) state_d = i2c_slave_pkg::ADDR_RCV;
                end

                i2c_slave_pkg::ADDR_RCV: begin
                    sda_oe_d = 1'b0;
                    if (ev.scl_rise) begin
                        ctl.addr_shift = 1'b1;
                        cnt_step       = 1'b1;
                        if (last_bit) begin  // R/W bit
                            status_d.addr_match = addr_hit;
                            state_d             = i2c_slave_pkg::ADDR_ACK;
                        end
                    end
                end

                i2c_slave_pkg::ADDR_ACK: begin
                    if (!status.addr_match) begin
                        // Not ours, stay off the bus
                        sda_oe_d = 1'b0;
                        state_d  = i2c_slave_pkg::WAIT_STOP;
                    end else if (ev.scl_fall && !status.ack_sent) begin
                        sda_oe_d          = 1'b1;  // ACK low
                        sda_out_d         = 1'b0;
                        status_d.ack_sent = 1'b1;
                    end else if (ev.scl_fall) begin
                        sda_oe_d = 1'b0;  // End of ACK clock
                        if (rw == i2c_slave_pkg::DIR_READ) begin
                            ctl.tx_load = 1'b1;
                            state_d     = i2c_slave_pkg::DATA_SEND;
                        end else begin
                            state_d = i2c_slave_pkg::DATA_RCV;
                        end
                    end
                end

                i2c_slave_pkg::DATA_RCV: begin
                    sda_oe_d = 1'b0;
                    if (ev.scl_rise) begin
                        ctl.rx_shift = 1'b1;
                        cnt_step     = 1'b1;
                        if (last_bit) begin
                            status_d.data_valid = 1'b1;
                            state_d             = i2c_slave_pkg::DATA_ACK;
                        end
                    end
                end

                i2c_slave_pkg::DATA_SEND: begin
                    // SDA follows transmit MSB, changes only after SCL fall
                    sda_oe_d  = 1'b1;
                    sda_out_d = tx_bit;
                    if (ev.scl_fall) ctl.tx_shift = 1'b1;
                    if (ev.scl_rise) begin
                        cnt_step = 1'b1;
                        if (last_bit) state_d = i2c_slave_pkg::DATA_ACK;
                    end
                end

                i2c_slave_pkg::DATA_ACK: begin
                    if (rw == i2c_slave_pkg::DIR_WRITE) begin
                        // sda_oe marks which half of the ACK clock we are in
                        if (ev.scl_fall && !sda_oe) begin
                            sda_oe_d  = 1'b1;
                            sda_out_d = 1'b0;
                        end else if (ev.scl_fall) begin
                            sda_oe_d = 1'b0;
                            state_d  = i2c_slave_pkg::WAIT_STOP;
                        end
                    end else begin
                        // Hold last data bit through SCL high, then let master answer
                        if (ev.scl_fall) sda_oe_d = 1'b0;
                        if (ev.scl_rise) state_d = i2c_slave_pkg::WAIT_STOP;  // ACK or NACK
                    end
                end

                i2c_slave_pkg::WAIT_STOP: begin
                    sda_oe_d = 1'b0;
                    if (ev.start) begin  // Repeated START
                        state_d           = i2c_slave_pkg::START;
                        cnt_clear         = 1'b1;
                        status_d.ack_sent = 1'b0;
                    end
                end

                default: begin
                    sda_oe_d = 1'b0;
                    state_d  = i2c_slave_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/i2c_slave_pkg.sv
package i2c_slave_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int ADDR_W    = 7;  // 7-bit slave address
    localparam int BYTE_W    = 8;  // Data byte
    localparam int BIT_CNT_W = 3;  // Bit index within a byte

    // ========================================
    // Enums
    // ========================================
    typedef enum logic [3:0] {
        IDLE      = 4'd0,  // Bus free, wait for START
        START     = 4'd1,  // START seen, wait for first SCL low
        ADDR_RCV  = 4'd2,  // Shift in address + R/W
        ADDR_ACK  = 4'd3,  // ACK clock for address
        DATA_RCV  = 4'd4,  // Write byte from master
        DATA_SEND = 4'd5,  // Read byte to master
        DATA_ACK  = 4'd6,  // ACK clock for data
        WAIT_STOP = 4'd7   // Done, wait for STOP or repeated START
    } i2c_state_t;

    // R/W bit of the address byte
    typedef enum logic {
        DIR_WRITE = 1'b0,
        DIR_READ  = 1'b1
    } i2c_dir_t;

    // ========================================
    // Structs
    // ========================================
    // Conditioned bus view, all in clk domain
    typedef struct packed {
        logic scl_rise;  // One-cycle pulse
        logic scl_fall;  // One-cycle pulse
        logic scl_high;  // Synchronized SCL level
        logic sda_in;    // Synchronized SDA level
        logic start;     // SDA fall while SCL high
        logic stop;      // SDA rise while SCL high
    } i2c_bus_ev_t;

    // Strobes from FSM to the shift registers
    typedef struct packed {
        logic addr_shift;
        logic rx_shift;
        logic tx_load;
        logic tx_shift;
    } i2c_shift_ctl_t;

    typedef struct packed {
        logic addr_match;
        logic ack_sent;
        logic data_valid;
    } i2c_status_t;

endpackage

// File: src/i2c_slave_top.sv
`timescale 1ns/1ps

module i2c_slave_top #(
    parameter int SYNC_STAGES = 3
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [i2c_slave_pkg::ADDR_W-1:0] slave_addr,
    input  logic [i2c_slave_pkg::BYTE_W-1:0] tx_data,
    output logic [i2c_slave_pkg::BYTE_W-1:0] rx_data,
    output i2c_slave_pkg::i2c_status_t       status,
    input  logic                             scl,
    inout  wire                              sda
);

    i2c_slave_pkg::i2c_bus_ev_t    ev;
    i2c_slave_pkg::i2c_shift_ctl_t ctl;
    i2c_slave_pkg::i2c_dir_t       rw;
    logic                          cnt_clear;
    logic                          cnt_step;
    logic                          last_bit;
    logic                          addr_hit;
    logic                          tx_bit;
    logic                          sda_out;
    logic                          sda_oe;

    // ========================================
    // SDA pad
    // ========================================
    assign sda = sda_oe ? sda_out : 1'bz;  // Slave drives SDA only while sda_oe is set

    i2c_line_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_line_sync (
        .clk     (clk),
        .rst_n   (rst_n),
        .scl     (scl),
        .sda_pin (sda),
        .ev      (ev)
    );

    i2c_bit_counter u_bit_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (cnt_clear),
        .step     (cnt_step),
        .last_bit (last_bit)
    );

    i2c_byte_path u_byte_path (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctl        (ctl),
        .sda_in     (ev.sda_in),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .rx_data    (rx_data),
        .addr_hit   (addr_hit),
        .rw         (rw),
        .tx_bit     (tx_bit)
    );

    i2c_slave_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .ev        (ev),
        .last_bit  (last_bit),
        .addr_hit  (addr_hit),
        .rw        (rw),
        .tx_bit    (tx_bit),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step),
        .ctl       (ctl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .status    (status)
    );

endmodule

// File: tb/tb_i2c_slave.sv
`timescale 1ns/1ps

module tb_i2c_slave;

    localparam logic [6:0] SLAVE_ADDR = 7'h3C;
    localparam int NUM_ROWS    = 7;
    localparam int RST_CYC     = 5;
    localparam int QTR         = 10;  // Quarter SCL period in clocks
    localparam int TIMEOUT_CYC = NUM_ROWS * 30 * 40 + RST_CYC + 500;

    // One table row per transfer
    typedef struct packed {
        logic [i2c_slave_pkg::ADDR_W-1:0] addr;
        i2c_slave_pkg::i2c_dir_t          dir;
        logic [i2c_slave_pkg::BYTE_W-1:0] data;  // Write byte or tx_data
        logic                             ack;   // Address ACK expected
        logic                             rep;   // Repeated START follows instead of STOP
    } xfer_t;

    logic                       clk;
    logic                       rst_n;
    logic                       scl;
    logic                       sda_low;  // Master open-drain enable
    logic [6:0]                 slave_addr;
    logic [7:0]                 tx_data;
    logic [7:0]                 rx_data;
    i2c_slave_pkg::i2c_status_t status;
    tri1                        sda;      // Pull-up on the bus

    xfer_t                      table_rows [NUM_ROWS];
    i2c_slave_pkg::i2c_status_t status_seen;  // Status at last SCL-high sample
    int unsigned                seed_val;
    int unsigned                rnd;
    int                         cycles = 0;
    int                         checks;
    int                         mismatches;
    int                         other_errs;
    int                         dv_count;     // data_valid pulses in current row
    logic                       silent;       // Non-matching transfer in progress

    assign sda = sda_low ? 1'b0 : 1'bz;

    i2c_slave_top #(
        .SYNC_STAGES(3)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .rx_data    (rx_data),
        .status     (status),
        .scl        (scl),
        .sda        (sda)
    );

    always #5 clk = ~clk;

    // ========================================
    // Monitors
    // ========================================
    always @(negedge clk) begin
        if (status.data_valid === 1'b1) dv_count++;
    end

    // Posedge sits halfway between master updates
    always @(posedge clk) begin
        if (silent && !sda_low && sda !== 1'b1) begin
            other_errs++;
            $display("SDA pulled low by the DUT during a non-matching transfer at %0t", $time);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Verification failed");
            $finish;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic xfer_t make_xfer(input logic [6:0] addr,
                                        input i2c_slave_pkg::i2c_dir_t dir,
                                        input logic [7:0] data,
                                        input logic ack,
                                        input logic rep);
        xfer_t x;
        x.addr = addr;
        x.dir  = dir;
        x.data = data;
        x.ack  = ack;
        x.rep  = rep;
        return x;
    endfunction

    // Entered from idle bus or with SCL low and leaves SCL low
    task automatic start_condition;
        wait_clocks(QTR);
        sda_low = 1'b0;
        wait_clocks(QTR);
        scl = 1'b1;
        wait_clocks(QTR);
        sda_low = 1'b1;  // SDA falls while SCL high
        wait_clocks(QTR);
        scl = 1'b0;
    endtask

    task automatic stop_condition;
        wait_clocks(QTR);
        sda_low = 1'b1;
        wait_clocks(QTR);
        scl = 1'b1;
        wait_clocks(QTR);
        sda_low = 1'b0;  // SDA rises while SCL high
        wait_clocks(QTR);
    endtask

    // One SCL period with data set up mid-low and sampled mid-high
    task automatic clock_bit(input logic b, output logic rd);
        wait_clocks(QTR);
        sda_low = !b;
        wait_clocks(QTR);
        scl = 1'b1;
        wait_clocks(QTR);
        rd          = sda;
        status_seen = status;
        wait_clocks(QTR);
        scl = 1'b0;
    endtask

    task automatic run_xfer(input xfer_t x);
        logic [7:0] addr_byte;
        logic [7:0] rd_byte;
        logic       rd;
        int         exp_dv;
        int         i;

        tx_data   = (x.dir == i2c_slave_pkg::DIR_READ) ? x.data : 8'h00;
        dv_count  = 0;
        exp_dv    = (x.ack && x.dir == i2c_slave_pkg::DIR_WRITE) ? 1 : 0;
        addr_byte = {x.addr, x.dir};
        start_condition();
        silent = !x.ack;

        for (i = 7; i >= 0; i--) begin
            clock_bit(addr_byte[i], rd);
        end
        clock_bit(1'b1, rd);  // Ninth clock for slave ACK
        compare("sda (address ack)", rd, !x.ack);
        compare("status.addr_match", status_seen.addr_match, x.ack);
        compare("status.ack_sent", status_seen.ack_sent, x.ack);

        if (x.dir == i2c_slave_pkg::DIR_WRITE) begin
            for (i = 7; i >= 0; i--) begin
                clock_bit(x.data[i], rd);
            end
            // Pulse must land before the data ACK clock
            if (dv_count != exp_dv) begin
                other_errs++;
                $display("Saw %0d data_valid pulses before the data ACK, expected %0d",
                         dv_count, exp_dv);
            end
            if (x.ack) compare("rx_data", rx_data, x.data);
            clock_bit(1'b1, rd);
            compare("sda (data ack)", rd, !x.ack);
        end else begin
            for (i = 7; i >= 0; i--) begin
                clock_bit(1'b1, rd);
                rd_byte[i] = rd;  // MSB first
            end
            compare("sda (read byte)", rd_byte, x.ack ? x.data : 8'hFF);
            clock_bit(1'b1, rd);  // Master NACK
        end

        if (dv_count != exp_dv) begin
            other_errs++;
            $display("data_valid pulsed %0d times in the transfer, expected %0d",
                     dv_count, exp_dv);
        end

        silent = 1'b0;
        if (!x.rep) begin
            stop_condition();
            compare("status.addr_match after STOP", status.addr_match, 1'b0);
            compare("status.ack_sent after STOP", status.ack_sent, 1'b0);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        logic [7:0] rand_wr;
        logic [7:0] rand_rd;
        int         r;

        clk        = 1'b0;
        rst_n      = 1'b0;
        scl        = 1'b1;  // Bus idle
        sda_low    = 1'b0;
        slave_addr = SLAVE_ADDR;
        tx_data    = 8'h00;
        silent     = 1'b0;
        checks     = 0;
        mismatches = 0;
        other_errs = 0;
        dv_count   = 0;

        seed_val = 32'h5360b46c;
        rnd      = $urandom(seed_val);
        rand_wr  = rnd[7:0];
        rand_rd  = $urandom % 256;

        table_rows[0] = make_xfer(SLAVE_ADDR, i2c_slave_pkg::DIR_WRITE, 8'hA5, 1'b1, 1'b0);
        table_rows[1] = make_xfer(SLAVE_ADDR, i2c_slave_pkg::DIR_READ, 8'h5A, 1'b1, 1'b0);
        table_rows[2] = make_xfer(7'h12, i2c_slave_pkg::DIR_WRITE, 8'hFF, 1'b0, 1'b0);
        table_rows[3] = make_xfer(SLAVE_ADDR, i2c_slave_pkg::DIR_WRITE, rand_wr, 1'b1, 1'b1);
        table_rows[4] = make_xfer(SLAVE_ADDR, i2c_slave_pkg::DIR_READ, rand_rd, 1'b1, 1'b0);
        table_rows[5] = make_xfer(7'h3D, i2c_slave_pkg::DIR_READ, 8'h00, 1'b0, 1'b1);
        table_rows[6] = make_xfer(SLAVE_ADDR, i2c_slave_pkg::DIR_WRITE, 8'h81, 1'b1, 1'b0);

        repeat (RST_CYC) @(negedge clk);
        compare("status after reset", status, 3'b000);
        rst_n = 1'b1;

        for (r = 0; r < NUM_ROWS; r++) begin
            run_xfer(table_rows[r]);
        end
        wait_clocks(QTR);

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
